/* include/thorDecode_params.svh */
// Thor decode stage parameters for the multi-cycle stall window and the data path width
`ifndef THOR_DECODE_PARAMS_SVH
`define THOR_DECODE_PARAMS_SVH

// ======================================================================
// Issue timing
// ======================================================================

// Cycles that ready stays low after a MUL or DIV is issued
`define THOR_MC_CYCLES 4

// ======================================================================
// Data path
// ======================================================================

// Width of immediates, displacements and branch targets after extension
`define THOR_VALUE_W 64

`endif

/* hw/thorDecodePkg.sv */
// Thor decode package with opcodes, function codes, instruction formats and the decode record
`default_nettype none

`include "thorDecode_params.svh"

package thorDecodePkg;

	typedef logic [`THOR_VALUE_W-1:0] Value;

	// ======================================================================
	// Opcodes and function codes
	// ======================================================================

	typedef enum logic [7:0]
	{
		R2    = 8'h02,
		ADDI  = 8'h04,
		ANDI  = 8'h08,
		ORI   = 8'h09,
		ADDIL = 8'h14,
		ANDIL = 8'h18,
		JMP   = 8'h20,
		JEQ   = 8'h26,
		EXI7  = 8'h50,
		EXI23 = 8'h51,
		LDB   = 8'h80,
		LDBU  = 8'h81,
		LDW   = 8'h82,
		LDO   = 8'h86,
		STB   = 8'h90,
		STO   = 8'h93,
		NOP   = 8'hF1
	} Opcode;

	// Function field of the R2 format
	typedef enum logic [5:0]
	{
		MUL  = 6'h08,
		MULH = 6'h09,
		DIV  = 6'h10,
		DIVU = 6'h11
	} R2Func;

	typedef enum logic [1:0]
	{
		byt   = 2'd0,
		wyde  = 2'd1,
		tetra = 2'd2,
		octa  = 2'd3
	} MemSize;

	// ======================================================================
	// Instruction formats, all 48 bits with the opcode in the low byte
	// ======================================================================

	typedef struct packed {
		logic [26:0] rest;
		logic [5:0] Ra;
		logic [5:0] Rt;
		logic v;
		Opcode opcode;
	} AnyFmt;

	// 11-bit immediate sits at the top of the word
	typedef struct packed {
		logic [10:0] imm;
		logic [15:0] pad;
		logic [5:0] Ra;
		logic [5:0] Rt;
		logic v;
		Opcode opcode;
	} RiFmt;

	typedef struct packed {
		logic [22:0] imm;
		logic [3:0] pad;
		logic [5:0] Ra;
		logic [5:0] Rt;
		logic v;
		Opcode opcode;
	} RilFmt;

	typedef struct packed {
		logic [23:0] disp;
		logic [2:0] pad;
		logic [5:0] Ra;
		logic [5:0] Rt;
		logic v;
		Opcode opcode;
	} LdFmt;

	// Store source register occupies the Rt slot
	typedef struct packed {
		logic [23:0] disp;
		logic [2:0] pad;
		logic [5:0] Ra;
		logic [5:0] Rs;
		logic v;
		Opcode opcode;
	} StFmt;

	typedef struct packed {
		R2Func func;
		logic [14:0] pad;
		logic [5:0] Rb;
		logic [5:0] Ra;
		logic [5:0] Rt;
		logic v;
		Opcode opcode;
	} R2Fmt;

	// Target is in half-word units
	typedef struct packed {
		logic [23:0] target;
		logic [2:0] Ca;
		logic [5:0] Ra;
		logic [3:0] pad;
		logic [1:0] lk;
		logic v;
		Opcode opcode;
	} JxxFmt;

	typedef struct packed {
		logic [38:0] payload;
		logic v;
		Opcode opcode;
	} ExiFmt;

	typedef union packed {
		AnyFmt any;
		RiFmt ri;
		RilFmt ril;
		LdFmt ld;
		StFmt st;
		R2Fmt r2;
		JxxFmt jxx;
		ExiFmt exi;
	} Instruction;

	// ======================================================================
	// Decode record
	// ======================================================================

	typedef struct packed {
		logic [5:0] Ra;
		logic [5:0] Rb;
		logic [5:0] Rc;
		logic [5:0] Rt;
		logic rfwr;
		Value imm;
		logic ld;
		logic ldz;
		logic st;
		MemSize memsz;
		logic jmp;
		logic jxx;
		logic [1:0] lk;
		logic carfwr;
		logic [2:0] Cat;
		Value jmpTgt;
		logic mul;
		logic div;
		logic multiCycle;
	} DecodeOut;

endpackage

`default_nettype wire

/* hw/thorPrefixLatch.sv */
// Thor prefix latch holding an EXI7 or EXI23 word until the next instruction is accepted
`timescale 1ns/1ps
`default_nettype none

module thorPrefixLatch
(
	input logic clk,
	input logic rstN,
	input logic irValid,
	input thorDecodePkg::Instruction ir,
	output logic prefixHit,
	output thorDecodePkg::Instruction xir
);

	// Extension word seen by the decoder when nothing is pending
	localparam logic [47:0] NopWord = {40'd0, thorDecodePkg::NOP};

	logic pending;
	thorDecodePkg::Instruction held;

	assign prefixHit = (ir.any.opcode == thorDecodePkg::EXI7) ||
		(ir.any.opcode == thorDecodePkg::EXI23);

	// Set by a prefix, cleared by the instruction that consumes it
	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
			pending <= 1'b0;
		else if (irValid)
			pending <= prefixHit;
	end

	always_ff @(posedge clk)
	begin
		if (irValid && prefixHit)
			held <= ir;
	end

	assign xir = pending ? held : NopWord;

	// Prefixes do not chain
	assert property (@(posedge clk) disable iff (!rstN) (pending && irValid) |-> !prefixHit)
		else $error("second prefix word while a prefix is pending");

endmodule

`default_nettype wire

/* hw/thorDecoder.sv */
// Thor instruction decoder turning an instruction and its prefix into a decode record
`timescale 1ns/1ps
`default_nettype none

`include "thorDecode_params.svh"

module thorDecoder
(
	input thorDecodePkg::Instruction ir,
	input thorDecodePkg::Instruction xir,
	output thorDecodePkg::DecodeOut deco
);

	thorDecodePkg::Value imm;

	always_comb
	begin
		deco = '0;

		// ======================================================================
		// Register fields
		// ======================================================================
		deco.Ra = ir.any.Ra;
		deco.Rb = ir.r2.Rb;

		// Branches never write a general register
		case (ir.any.opcode)
		thorDecodePkg::JMP, thorDecodePkg::JEQ:
			deco.Rt = 6'd0;
		default:
			deco.Rt = ir.any.Rt;
		endcase

		case (ir.any.opcode)
		thorDecodePkg::STB, thorDecodePkg::STO:
			deco.Rc = ir.st.Rs;
		default:
			deco.Rc = ir.any.rest[13:8];
		endcase

		case (ir.any.opcode)
		thorDecodePkg::ADDI, thorDecodePkg::ANDI, thorDecodePkg::ORI,
		thorDecodePkg::ADDIL, thorDecodePkg::ANDIL, thorDecodePkg::R2:
			deco.rfwr = 1'b1;
		default:
			deco.rfwr = 1'b0;
		endcase

		// ======================================================================
		// Immediate constant
		// ======================================================================
		case (ir.any.opcode)
		thorDecodePkg::ADDI:
			imm = {{(`THOR_VALUE_W-11){ir.ri.imm[10]}}, ir.ri.imm};
		// Mask constants keep the upper bits
		thorDecodePkg::ANDI:
			imm = {{(`THOR_VALUE_W-11){1'b1}}, ir.ri.imm};
		thorDecodePkg::ORI:
			imm = {{(`THOR_VALUE_W-11){1'b0}}, ir.ri.imm};
		thorDecodePkg::ADDIL:
			imm = {{(`THOR_VALUE_W-23){ir.ril.imm[22]}}, ir.ril.imm};
		thorDecodePkg::ANDIL:
			imm = {{(`THOR_VALUE_W-23){1'b1}}, ir.ril.imm};
		// Stores hold the displacement in the same bits as loads
		thorDecodePkg::LDB, thorDecodePkg::LDBU, thorDecodePkg::LDW, thorDecodePkg::LDO,
		thorDecodePkg::STB, thorDecodePkg::STO:
			imm = {{(`THOR_VALUE_W-24){ir.ld.disp[23]}}, ir.ld.disp};
		default:
			imm = '0;
		endcase

		// Prefix supplies everything above bit 22
		case (xir.any.opcode)
		thorDecodePkg::EXI7:
			imm = {{(`THOR_VALUE_W-30){xir.exi.payload[6]}}, xir.exi.payload[6:0], imm[22:0]};
		thorDecodePkg::EXI23:
			imm = {{(`THOR_VALUE_W-46){xir.exi.payload[22]}}, xir.exi.payload[22:0],
				imm[22:0]};
		default:
			;
		endcase
		deco.imm = imm;

		// ======================================================================
		// Memory access
		// ======================================================================
		case (ir.any.opcode)
		thorDecodePkg::LDB, thorDecodePkg::LDBU, thorDecodePkg::LDW, thorDecodePkg::LDO:
			deco.ld = 1'b1;
		default:
			deco.ld = 1'b0;
		endcase
		deco.ldz = (ir.any.opcode == thorDecodePkg::LDBU);
		deco.st = (ir.any.opcode == thorDecodePkg::STB) || (ir.any.opcode == thorDecodePkg::STO);

		case (ir.any.opcode)
		thorDecodePkg::LDB, thorDecodePkg::LDBU, thorDecodePkg::STB:
			deco.memsz = thorDecodePkg::byt;
		thorDecodePkg::LDW:
			deco.memsz = thorDecodePkg::wyde;
		default:
			deco.memsz = thorDecodePkg::octa;
		endcase

		// ======================================================================
		// Branches
		// ======================================================================
		deco.jmp = (ir.any.opcode == thorDecodePkg::JMP);
		deco.jxx = (ir.any.opcode == thorDecodePkg::JEQ);
		if (deco.jmp || deco.jxx)
		begin
			// Link goes to ca[lk], ca[0] is never written
			deco.lk = ir.jxx.lk;
			deco.carfwr = (ir.jxx.lk != 2'd0);
			deco.Cat = {1'b0, ir.jxx.lk};
			deco.jmpTgt = {{(`THOR_VALUE_W-25){ir.jxx.target[23]}}, ir.jxx.target, 1'b0};
		end

		// Multiply and divide hold the issue port
		if (ir.any.opcode == thorDecodePkg::R2)
		begin
			case (ir.r2.func)
			thorDecodePkg::MUL, thorDecodePkg::MULH:
				deco.mul = 1'b1;
			thorDecodePkg::DIV, thorDecodePkg::DIVU:
				deco.div = 1'b1;
			default:
				;
			endcase
		end
		deco.multiCycle = deco.mul | deco.div;
	end

endmodule

`default_nettype wire

/* hw/thorStallTimer.sv */
// Thor stall timer counting down the not-ready window after a multi-cycle issue
`timescale 1ns/1ps
`default_nettype none

`include "thorDecode_params.svh"

module thorStallTimer
(
	input logic clk,
	input logic rstN,
	input logic start,
	output logic busy
);

	localparam int CntW = $clog2(`THOR_MC_CYCLES + 1);

	logic [CntW-1:0] count;

	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
			count <= '0;
		else if (start)
			count <= CntW'(`THOR_MC_CYCLES);
		else if (count != '0)
			count <= count - CntW'(1);
	end

	assign busy = (count != '0);

	// The controller keeps the input closed until the count has run out
	assert property (@(posedge clk) disable iff (!rstN) start |-> !busy)
		else $error("stall timer restarted while busy");

endmodule

`default_nettype wire

/* hw/thorIssueCtrl.sv */
// Thor issue controller registering the decode record and pacing the input with ready
`timescale 1ns/1ps
`default_nettype none

`include "thorDecode_params.svh"

module thorIssueCtrl
(
	input logic clk,
	input logic rstN,
	input logic irValid,
	input logic prefixHit,
	input logic busy,
	input thorDecodePkg::DecodeOut decoIn,
	output logic decoValid,
	output thorDecodePkg::DecodeOut deco,
	output logic ready,
	output logic start
);

	typedef enum logic [1:0] {IDLE, ISSUE, STALL} State;

	State state;
	logic accept;

	// Input closes only while a multi-cycle op is still counting
	assign ready = !(state == STALL && busy);
	assign accept = irValid && ready && !prefixHit;
	assign start = accept && decoIn.multiCycle;

	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
		begin
			state <= IDLE;
			decoValid <= 1'b0;
			deco <= '0;
		end
		else
		begin
			decoValid <= accept;
			if (accept)
			begin
				deco <= decoIn;
				state <= decoIn.multiCycle ? STALL : ISSUE;
			end
			else
			begin
				case (state)
				ISSUE:
					state <= IDLE;
				STALL:
					if (!busy)
						state <= IDLE;
				default:
					state <= IDLE;
				endcase
			end
		end
	end

	// Source must honour ready
	assert property (@(posedge clk) disable iff (!rstN) irValid |-> ready)
		else $error("irValid asserted while ready is low");

	// Full stall window, then the input reopens
	assert property (@(posedge clk) disable iff (!rstN)
		start |=> (!ready [*`THOR_MC_CYCLES]) ##1 ready)
		else $error("ready low for the wrong number of cycles after a multi-cycle issue");

endmodule

`default_nettype wire

/* hw/thorDecodeStage.sv */
// Thor decode stage top joining prefix latch, decoder, issue controller and stall timer
`timescale 1ns/1ps
`default_nettype none

module thorDecodeStage
(
	input logic clk,
	input logic rstN,
	input logic irValid,
	input thorDecodePkg::Instruction ir,
	output logic ready,
	output logic decoValid,
	output thorDecodePkg::DecodeOut deco
);

	logic prefixHit;
	logic busy;
	logic start;
	thorDecodePkg::Instruction xir;
	thorDecodePkg::DecodeOut decoComb;

	thorPrefixLatch u_prefix
	(
		.clk(clk),
		.rstN(rstN),
		.irValid(irValid),
		.ir(ir),
		.prefixHit(prefixHit),
		.xir(xir)
	);

	// Zero-latency decode of the word on the input
	thorDecoder u_decoder
	(
		.ir(ir),
		.xir(xir),
		.deco(decoComb)
	);

	thorIssueCtrl u_issue
	(
		.clk(clk),
		.rstN(rstN),
		.irValid(irValid),
		.prefixHit(prefixHit),
		.busy(busy),
		.decoIn(decoComb),
		.decoValid(decoValid),
		.deco(deco),
		.ready(ready),
		.start(start)
	);

	thorStallTimer u_timer
	(
		.clk(clk),
		.rstN(rstN),
		.start(start),
		.busy(busy)
	);

endmodule

`default_nettype wire

/* verification/thorDecodeStage_tb.sv */
// Thor decode stage testbench checking decode records, prefix merging and ready pacing
`timescale 1ns/1ps
`default_nettype none

`include "thorDecode_params.svh"

module thorDecodeStage_tb;

	localparam int AluWords = 40;
	localparam int PrefixWords = 8;
	localparam int MemWords = 24;
	localparam int BrWords = 12;
	localparam int McWords = 8;
	localparam int BtbWords = 6;
	localparam int NumWords = AluWords + PrefixWords + MemWords + BrWords + McWords + BtbWords;
	localparam int WatchdogCycles = NumWords * (`THOR_MC_CYCLES + 2) + 100;
	localparam logic [47:0] NopWord = {40'd0, thorDecodePkg::NOP};

	logic clk;
	logic rstN;
	logic irValid;
	thorDecodePkg::Instruction ir;
	logic ready;
	logic decoValid;
	thorDecodePkg::DecodeOut deco;

	// Expected records in issue order, and the prefix the source has sent
	thorDecodePkg::DecodeOut expQ[$];
	thorDecodePkg::DecodeOut expRec;
	logic tbPending;
	thorDecodePkg::Instruction tbPrefix;

	logic [31:0] lcgState = 32'd79829;
	int errors = 0;
	int checks = 0;
	int lowRun = 0;
	int mcWindows = 0;
	int validRun = 0;
	int maxValidRun = 0;

	thorDecodeStage u_dut
	(
		.clk(clk),
		.rstN(rstN),
		.irValid(irValid),
		.ir(ir),
		.ready(ready),
		.decoValid(decoValid),
		.deco(deco)
	);

	always
	begin
		#10 clk = ~clk;
	end

	// ======================================================================
	// Helpers
	// ======================================================================

	function automatic logic [31:0] nextRand();
		lcgState = lcgState * 32'd1664525 + 32'd1013904223;
		return lcgState;
	endfunction

	function automatic thorDecodePkg::Instruction randWord();
		logic [31:0] hi;
		logic [31:0] lo;
		hi = nextRand();
		lo = nextRand();
		return {hi, lo[31:16]};
	endfunction

	function automatic thorDecodePkg::Value signExtend(input thorDecodePkg::Value raw,
		input int width);
		thorDecodePkg::Value upper;
		upper = ~thorDecodePkg::Value'(0) << width;
		if (raw[width-1])
			return raw | upper;
		else
			return raw & ~upper;
	endfunction

	// Expected decode record from the instruction rules
	function automatic thorDecodePkg::DecodeOut refDecode(input thorDecodePkg::Instruction w,
		input thorDecodePkg::Instruction x);
		thorDecodePkg::DecodeOut d;
		thorDecodePkg::Opcode op;
		thorDecodePkg::Value upper;
		logic isLoad;
		logic isStore;
		logic isBranch;
		d = '0;
		op = w.any.opcode;
		upper = ~thorDecodePkg::Value'(0);
		isLoad = op inside {thorDecodePkg::LDB, thorDecodePkg::LDBU, thorDecodePkg::LDW,
			thorDecodePkg::LDO};
		isStore = op inside {thorDecodePkg::STB, thorDecodePkg::STO};
		isBranch = op inside {thorDecodePkg::JMP, thorDecodePkg::JEQ};

		d.Ra = w.any.Ra;
		d.Rb = w.r2.Rb;
		d.Rt = isBranch ? 6'd0 : w.any.Rt;
		d.Rc = isStore ? w.st.Rs : 6'd0;
		d.rfwr = op inside {thorDecodePkg::ADDI, thorDecodePkg::ANDI, thorDecodePkg::ORI,
			thorDecodePkg::ADDIL, thorDecodePkg::ANDIL, thorDecodePkg::R2};

		if (op == thorDecodePkg::ADDI)
			d.imm = signExtend(thorDecodePkg::Value'(w.ri.imm), 11);
		else if (op == thorDecodePkg::ANDI)
			d.imm = thorDecodePkg::Value'(w.ri.imm) | (upper << 11);
		else if (op == thorDecodePkg::ORI)
			d.imm = thorDecodePkg::Value'(w.ri.imm);
		else if (op == thorDecodePkg::ADDIL)
			d.imm = signExtend(thorDecodePkg::Value'(w.ril.imm), 23);
		else if (op == thorDecodePkg::ANDIL)
			d.imm = thorDecodePkg::Value'(w.ril.imm) | (upper << 23);
		else if (isLoad)
			d.imm = signExtend(thorDecodePkg::Value'(w.ld.disp), 24);
		else if (isStore)
			d.imm = signExtend(thorDecodePkg::Value'(w.st.disp), 24);

		// Prefix payload goes above bit 22
		if (x.any.opcode == thorDecodePkg::EXI7)
			d.imm = (signExtend(thorDecodePkg::Value'(x.exi.payload[6:0]), 7) << 23) |
				(d.imm & ~(upper << 23));
		else if (x.any.opcode == thorDecodePkg::EXI23)
			d.imm = (signExtend(thorDecodePkg::Value'(x.exi.payload[22:0]), 23) << 23) |
				(d.imm & ~(upper << 23));

		d.ld = isLoad;
		d.ldz = (op == thorDecodePkg::LDBU);
		d.st = isStore;
		if (op inside {thorDecodePkg::LDB, thorDecodePkg::LDBU, thorDecodePkg::STB})
			d.memsz = thorDecodePkg::byt;
		else if (op == thorDecodePkg::LDW)
			d.memsz = thorDecodePkg::wyde;
		else
			d.memsz = thorDecodePkg::octa;

		d.jmp = (op == thorDecodePkg::JMP);
		d.jxx = (op == thorDecodePkg::JEQ);
		if (isBranch)
		begin
			d.lk = w.jxx.lk;
			d.carfwr = (w.jxx.lk != 2'd0);
			d.Cat = {1'b0, w.jxx.lk};
			d.jmpTgt = signExtend(thorDecodePkg::Value'(w.jxx.target), 24) << 1;
		end

		if (op == thorDecodePkg::R2)
		begin
			d.mul = w.r2.func inside {thorDecodePkg::MUL, thorDecodePkg::MULH};
			d.div = w.r2.func inside {thorDecodePkg::DIV, thorDecodePkg::DIVU};
		end
		d.multiCycle = d.mul || d.div;
		return d;
	endfunction

	task automatic checkField(input string name, input logic [63:0] expV,
		input logic [63:0] gotV);
		checks++;
		if (expV !== gotV)
		begin
			errors++;
			$display("Error at %0t ns: %s expected %h got %h", $time, name, expV, gotV);
		end
	endtask

	task automatic reportTest(input string name, input int errBefore);
		if (errors == errBefore)
			$display("Test %s: passed", name);
		else
			$display("Test %s: failed with %0d errors", name, errors - errBefore);
	endtask

	// Drive one word at the first cycle with ready high and log what it should decode to
	task automatic sendWord(input thorDecodePkg::Instruction w);
		@(posedge clk);
		#2;
		while (!ready)
		begin
			irValid = 1'b0;
			@(posedge clk);
			#2;
		end
		irValid = 1'b1;
		ir = w;
		if (w.any.opcode inside {thorDecodePkg::EXI7, thorDecodePkg::EXI23})
		begin
			tbPending = 1'b1;
			tbPrefix = w;
		end
		else
		begin
			expQ.push_back(refDecode(w, tbPending ? tbPrefix : NopWord));
			tbPending = 1'b0;
		end
	endtask

	// Stop driving and wait for outstanding records and any stall to finish
	task automatic drain();
		int guard;
		guard = 0;
		@(posedge clk);
		#2;
		irValid = 1'b0;
		while ((expQ.size() != 0 || !ready) && guard < 4 * (`THOR_MC_CYCLES + 2))
		begin
			@(posedge clk);
			guard++;
		end
		repeat (2) @(posedge clk);
		if (expQ.size() != 0)
		begin
			errors++;
			$display("Error at %0t ns: %0d decoded records never appeared", $time, expQ.size());
			expQ.delete();
		end
	endtask

	// ======================================================================
	// Comparing process and ready monitor, sampled mid-cycle
	// ======================================================================

	always @(negedge clk)
	begin
		if (rstN && decoValid)
		begin
			if (expQ.size() == 0)
			begin
				errors++;
				$display("Error at %0t ns: decoValid high with no instruction outstanding", $time);
			end
			else
			begin
				expRec = expQ.pop_front();
				checkField("Ra", expRec.Ra, deco.Ra);
				checkField("Rb", expRec.Rb, deco.Rb);
				checkField("Rt", expRec.Rt, deco.Rt);
				checkField("rfwr", expRec.rfwr, deco.rfwr);
				checkField("imm", expRec.imm, deco.imm);
				checkField("ld", expRec.ld, deco.ld);
				checkField("ldz", expRec.ldz, deco.ldz);
				checkField("st", expRec.st, deco.st);
				checkField("memsz", 64'(expRec.memsz), 64'(deco.memsz));
				checkField("jmp", expRec.jmp, deco.jmp);
				checkField("jxx", expRec.jxx, deco.jxx);
				checkField("lk", expRec.lk, deco.lk);
				checkField("carfwr", expRec.carfwr, deco.carfwr);
				checkField("Cat", expRec.Cat, deco.Cat);
				checkField("jmpTgt", expRec.jmpTgt, deco.jmpTgt);
				checkField("mul", expRec.mul, deco.mul);
				checkField("div", expRec.div, deco.div);
				checkField("multiCycle", expRec.multiCycle, deco.multiCycle);
				if (expRec.st)
					checkField("Rc", expRec.Rc, deco.Rc);
			end
		end

		// Back-to-back issue length
		if (decoValid)
		begin
			validRun++;
			if (validRun > maxValidRun)
				maxValidRun = validRun;
		end
		else
			validRun = 0;

		// Stall window must start with a multi-cycle issue and last the full count
		if (rstN && !ready)
		begin
			if (lowRun == 0 && !(decoValid && deco.multiCycle))
			begin
				errors++;
				$display("Error at %0t ns: ready dropped without a multi-cycle issue", $time);
			end
			lowRun++;
		end
		else if (lowRun != 0)
		begin
			checkField("ready low cycles", `THOR_MC_CYCLES, lowRun);
			mcWindows++;
			lowRun = 0;
		end
	end

	// Ends a hung run
	initial
	begin
		repeat (WatchdogCycles) @(posedge clk);
		$display("Watchdog expired after %0d cycles", WatchdogCycles);
		$display("Simulation FAILED");
		$finish;
	end

	// ======================================================================
	// Test sequence
	// ======================================================================

	initial
	begin
		thorDecodePkg::Instruction w;
		logic [31:0] r;
		int errBefore;
		int windowsBefore;

		clk = 1'b0;
		rstN = 1'b0;
		irValid = 1'b0;
		ir = '0;
		tbPending = 1'b0;
		tbPrefix = NopWord;

		// Reset, sampled from the first clock edge on
		errBefore = errors;
		@(posedge clk);
		repeat (15)
		begin
			@(negedge clk);
			checkField("decoValid", 1'b0, decoValid);
			checkField("deco", 64'd0, 64'(deco != '0));
			checkField("ready", 1'b1, ready);
		end
		@(posedge clk);
		#2;
		rstN = 1'b1;
		repeat (2)
		begin
			@(negedge clk);
			checkField("decoValid", 1'b0, decoValid);
			checkField("deco", 64'd0, 64'(deco != '0));
			checkField("ready", 1'b1, ready);
		end
		reportTest("reset", errBefore);

		// ALU immediates
		errBefore = errors;
		for (int i = 0; i < AluWords; i++)
		begin
			w = randWord();
			r = nextRand();
			case (r[20:16] % 5)
			0: w.any.opcode = thorDecodePkg::ADDI;
			1: w.any.opcode = thorDecodePkg::ANDI;
			2: w.any.opcode = thorDecodePkg::ORI;
			3: w.any.opcode = thorDecodePkg::ADDIL;
			default: w.any.opcode = thorDecodePkg::ANDIL;
			endcase
			sendWord(w);
		end
		drain();
		reportTest("ALU immediates", errBefore);

		// Prefix alone gives nothing, then applies to one instruction only
		errBefore = errors;
		w = randWord();
		w.any.opcode = thorDecodePkg::EXI7;
		sendWord(w);
		drain();
		for (int i = 0; i < 7; i++)
		begin
			w = randWord();
			case (i)
			2: w.any.opcode = thorDecodePkg::EXI23;
			5: w.any.opcode = thorDecodePkg::EXI7;
			6: w.any.opcode = thorDecodePkg::ANDI;
			default: w.any.opcode = thorDecodePkg::ADDI;
			endcase
			sendWord(w);
		end
		drain();
		reportTest("prefix extension", errBefore);

		// Loads and stores
		errBefore = errors;
		for (int i = 0; i < MemWords; i++)
		begin
			w = randWord();
			case (i % 6)
			0: w.any.opcode = thorDecodePkg::LDB;
			1: w.any.opcode = thorDecodePkg::LDBU;
			2: w.any.opcode = thorDecodePkg::LDW;
			3: w.any.opcode = thorDecodePkg::LDO;
			4: w.any.opcode = thorDecodePkg::STB;
			default: w.any.opcode = thorDecodePkg::STO;
			endcase
			sendWord(w);
		end
		drain();
		reportTest("loads and stores", errBefore);

		// Branches
		errBefore = errors;
		for (int i = 0; i < BrWords; i++)
		begin
			w = randWord();
			w.any.opcode = (i % 2 == 0) ? thorDecodePkg::JMP : thorDecodePkg::JEQ;
			sendWord(w);
		end
		drain();
		reportTest("branches", errBefore);

		// Multiply and divide stall the input
		errBefore = errors;
		windowsBefore = mcWindows;
		for (int i = 0; i < McWords; i++)
		begin
			w = randWord();
			w.any.opcode = thorDecodePkg::R2;
			case (i % 4)
			0: w.r2.func = thorDecodePkg::MUL;
			1: w.r2.func = thorDecodePkg::DIV;
			2: w.r2.func = thorDecodePkg::MULH;
			default: w.r2.func = thorDecodePkg::DIVU;
			endcase
			sendWord(w);
		end
		drain();
		if (mcWindows - windowsBefore != McWords)
		begin
			errors++;
			$display("Error at %0t ns: saw %0d stall windows for %0d multi-cycle words",
				$time, mcWindows - windowsBefore, McWords);
		end

		// Single-cycle words issue every cycle
		maxValidRun = 0;
		for (int i = 0; i < BtbWords; i++)
		begin
			w = randWord();
			w.any.opcode = thorDecodePkg::ORI;
			sendWord(w);
		end
		drain();
		checkField("consecutive decoValid", BtbWords, maxValidRun);
		reportTest("multi-cycle", errBefore);

		$display("Checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* src.f */
+incdir+include
hw/thorDecodePkg.sv
hw/thorPrefixLatch.sv
hw/thorDecoder.sv
hw/thorStallTimer.sv
hw/thorIssueCtrl.sv
hw/thorDecodeStage.sv
verification/thorDecodeStage_tb.sv

/* Bender.yml */
package:
  name: thor_decode_stage

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - hw/thorDecodePkg.sv
      - hw/thorPrefixLatch.sv
      - hw/thorDecoder.sv
      - hw/thorStallTimer.sv
      - hw/thorIssueCtrl.sv
      - hw/thorDecodeStage.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - verification/thorDecodeStage_tb.sv
